// ==== hdl/cpu_board_params.svh ====
`ifndef CPU_BOARD_PARAMS_SVH
`define CPU_BOARD_PARAMS_SVH

// byte address width on fetch and data ports
`define CB_ADDR_W 16

// shared word memory, 2048 words of 32 bits
`define CB_MEM_WORDS 2048
`define CB_WORD_IDX_W 11

// address map
`define CB_ROM_BASE 16'h0000
`define CB_RAM_BASE 16'h1000
`define CB_ART_BASE 16'h2000
`define CB_KEY_BASE 16'h2008

// start, 8 data, parity, stop
`define CB_PS2_FRAME_BITS 11

`endif

// ==== hdl/board_pkg.sv ====
package board_pkg;

    // owner of the memory port in a given cycle
    typedef enum logic [1:0] {
        grant_none,
        grant_data,
        grant_fetch
    } arb_grant_e;

    // data bus target
    typedef enum logic [1:0] {
        dev_mem,
        dev_key,
        dev_uart,
        dev_none
    } dev_sel_e;

    // ps2 frame receive states
    typedef enum logic [1:0] {
        ps2_idle,
        ps2_shift,
        ps2_check
    } ps2_state_e;

    // interrupt vector codes seen by the cpu
    typedef enum logic [3:0] {
        irq_none     = 4'd0,
        irq_keyboard = 4'd1
    } irq_vec_e;

endpackage

// ==== hdl/mem_bus_if.sv ====
`timescale 1ns/1ps
`include "cpu_board_params.svh"

// one word-wide memory access path
// req is a single-cycle level, read data follows one cycle later
interface mem_bus_if;

    logic                      req;
    logic                      we;
    logic [`CB_WORD_IDX_W-1:0] idx;
    logic [31:0]               wdata;
    logic [31:0]               rdata;

    // side that issues accesses
    modport requester (
        output req, we, idx, wdata,
        input  rdata
    );

    // side that serves them
    modport responder (
        input  req, we, idx, wdata,
        output rdata
    );

endinterface

// ==== hdl/word_memory.sv ====
`timescale 1ns/1ps
`include "cpu_board_params.svh"

// single-port synchronous word ram
// write lands on the request edge, read data appears one cycle later
module word_memory (
    input  logic         CLOCK_50,
    mem_bus_if.responder mem
);

    // block ram array, contents undefined at power up
    logic [31:0] words [0:`CB_MEM_WORDS-1];

    // registered read port
    logic [31:0] rdata_q;

    always_ff @(posedge CLOCK_50) begin
        if (mem.req) begin
            if (mem.we) begin
                words[mem.idx] <= mem.wdata;
            end else begin
                // read only on non-write requests, output otherwise holds
                rdata_q <= words[mem.idx];
            end
        end
    end

    assign mem.rdata = rdata_q;

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps
`include "cpu_board_params.svh"

// shares the word memory between the data bus and instruction fetch
// data side always wins, fetch waits and is told by fetch_valid
module mem_arbiter import board_pkg::*; (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    mem_bus_if.responder          data_side,
    mem_bus_if.requester          ram,
    input  logic                  fetch_req,
    input  logic [`CB_ADDR_W-1:0] fetch_addr,
    output logic                  fetch_valid,
    output logic [31:0]           instruction
);

    // grant this cycle
    arb_grant_e grant;
    // owner of the word now coming out of the ram
    arb_grant_e grant_q;

    logic [`CB_WORD_IDX_W-1:0] fetch_idx;
    // index of the fetch issued last cycle
    logic [`CB_WORD_IDX_W-1:0] fetch_idx_q;
    logic                      fetch_repeat;
    logic                      fetch_ok;

    // byte address to word index
    assign fetch_idx = fetch_addr[`CB_WORD_IDX_W+1:2];

    // requester still shows the returning fetch's address
    // so do not issue that one twice
    assign fetch_repeat = (grant_q == grant_fetch) && (fetch_idx == fetch_idx_q);
    assign fetch_ok     = fetch_req && !fetch_repeat;

    // fixed priority pick
    always_comb begin
        if (data_side.req) begin
            grant = grant_data;
        end else if (fetch_ok) begin
            grant = grant_fetch;
        end else begin
            grant = grant_none;
        end
    end

    // forward the winner to the ram
    assign ram.req   = (grant != grant_none);
    assign ram.we    = (grant == grant_data) && data_side.we;
    assign ram.idx   = (grant == grant_data) ? data_side.idx : fetch_idx;
    assign ram.wdata = data_side.wdata;

    // remember who gets the read data next cycle
    // writes return nothing
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            grant_q <= grant_none;
        end else begin
            grant_q <= ram.we ? grant_none : grant;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (grant == grant_fetch) begin
            fetch_idx_q <= fetch_idx;
        end
    end

    // return paths
    assign data_side.rdata = (grant_q == grant_data) ? ram.rdata : '0;
    assign fetch_valid     = (grant_q == grant_fetch);

    // memory holds words little endian, core wants them reversed
    assign instruction = {ram.rdata[7:0], ram.rdata[15:8],
                          ram.rdata[23:16], ram.rdata[31:24]};

endmodule

// ==== hdl/data_bus_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_board_params.svh"

// cpu data bus decode into memory, keyboard register and console strobe
module data_bus_decoder import board_pkg::*; (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic [`CB_ADDR_W-1:0] bus_addr,
    input  logic                  bus_read,
    input  logic                  bus_write,
    input  logic [63:0]           bus_wdata,
    output logic [63:0]           bus_rdata,
    mem_bus_if.requester          mem,
    input  logic [7:0]            scan_code,
    output logic [7:0]            uart_data,
    output logic                  uart_strobe
);

    // size of the memory window in bytes
    localparam int MEM_BYTES = `CB_MEM_WORDS * 4;

    dev_sel_e              sel;
    // target of last cycle's read
    dev_sel_e              sel_q;
    logic [`CB_ADDR_W-1:0] mem_off;
    logic                  rd_q;
    logic [63:0]           read_mux;
    logic [63:0]           rdata_hold;
    logic                  art_wr;
    logic                  art_wr_q;
    logic [7:0]            uart_byte_q;

    // offset into the rom/ram window
    assign mem_off = bus_addr - `CB_ROM_BASE;

    // address classification
    always_comb begin
        if (bus_addr == `CB_KEY_BASE) begin
            sel = dev_key;
        end else if (bus_addr == `CB_ART_BASE) begin
            sel = dev_uart;
        end else if (32'(mem_off) < MEM_BYTES) begin
            sel = dev_mem;
        end else begin
            // unmapped io space
            sel = dev_none;
        end
    end

    // memory accesses go straight out to the arbiter
    assign mem.req   = (bus_read || bus_write) && (sel == dev_mem);
    assign mem.we    = bus_write;
    assign mem.idx   = mem_off[`CB_WORD_IDX_W+1:2];
    assign mem.wdata = bus_wdata[31:0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_q  <= 1'b0;
            sel_q <= dev_none;
        end else begin
            rd_q <= bus_read;
            if (bus_read) begin
                sel_q <= sel;
            end
        end
    end

    // read return source, zero extended
    always_comb begin
        unique case (sel_q)
            dev_mem: read_mux = {32'b0, mem.rdata};
            dev_key: read_mux = {56'b0, scan_code};
            default: read_mux = '0;
        endcase
    end

    // keep the last read result on the bus between reads
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rdata_hold <= '0;
        end else if (rd_q) begin
            rdata_hold <= read_mux;
        end
    end

    assign bus_rdata = rd_q ? read_mux : rdata_hold;

    // console write strobe, first cycle of the write only
    assign art_wr = bus_write && (sel == dev_uart);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            art_wr_q    <= 1'b0;
            uart_byte_q <= 8'h00;
        end else begin
            art_wr_q <= art_wr;
            if (uart_strobe) begin
                uart_byte_q <= bus_wdata[7:0];
            end
        end
    end

    assign uart_strobe = art_wr && !art_wr_q;
    // byte is valid with the strobe and held until the next one
    assign uart_data   = uart_strobe ? bus_wdata[7:0] : uart_byte_q;

endmodule

// ==== hdl/ps2_receiver.sv ====
`timescale 1ns/1ps
`include "cpu_board_params.svh"

// ps2 keyboard receiver
// deframes 11-bit frames, odd parity, tracks F0 break prefix
module ps2_receiver import board_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] scan_code,
    output logic       key_pressed,
    output logic       key_released
);

    // bits after the start bit: data, parity, stop
    localparam int         TAIL_BITS  = `CB_PS2_FRAME_BITS - 1;
    localparam logic [3:0] LAST_BIT   = 4'(TAIL_BITS - 1);
    localparam logic [7:0] BREAK_CODE = 8'hf0;
    localparam logic [7:0] EXT_CODE   = 8'he0;

    logic [1:0]           clk_sync;
    logic [1:0]           dat_sync;
    logic                 clk_prev;
    logic                 clk_fall;
    ps2_state_e           state;
    logic [3:0]           bit_cnt;
    logic [TAIL_BITS-1:0] frame;
    logic [7:0]           code;
    logic                 parity_ok;
    logic                 stop_ok;
    logic                 break_armed;

    // two-flop synchronizers, lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // device changes data on rising edge, sample on falling
    assign clk_fall = clk_prev && !clk_sync[1];

    // shift in lsb first, stop bit ends up on top
    always_ff @(posedge CLOCK_50) begin
        if (state == ps2_shift && clk_fall) begin
            frame <= {dat_sync[1], frame[TAIL_BITS-1:1]};
        end
    end

    assign code      = frame[7:0];
    // odd parity over data plus parity bit
    assign parity_ok = ^frame[8:0];
    assign stop_ok   = frame[TAIL_BITS-1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state        <= ps2_idle;
            bit_cnt      <= 4'd0;
            break_armed  <= 1'b0;
            scan_code    <= 8'h00;
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
        end else begin
            // single-cycle pulses
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
            case (state)
                ps2_idle: begin
                    // wait for a low start bit
                    if (clk_fall && !dat_sync[1]) begin
                        state   <= ps2_shift;
                        bit_cnt <= 4'd0;
                    end
                end
                ps2_shift: begin
                    if (clk_fall) begin
                        if (bit_cnt == LAST_BIT) begin
                            state <= ps2_check;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                ps2_check: begin
                    state <= ps2_idle;
                    // bad frames vanish here
                    if (parity_ok && stop_ok) begin
                        if (code == BREAK_CODE) begin
                            break_armed <= 1'b1;
                        end else if (code != EXT_CODE) begin
                            if (break_armed) begin
                                key_released <= 1'b1;
                                break_armed  <= 1'b0;
                            end else begin
                                key_pressed <= 1'b1;
                                scan_code   <= code;
                            end
                        end
                    end
                end
                default: state <= ps2_idle;
            endcase
        end
    end

endmodule

// ==== hdl/irq_controller.sv ====
`timescale 1ns/1ps

// single source interrupt controller for the keyboard
module irq_controller import board_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     key_pressed,
    input  logic     irq_ack,
    output irq_vec_e irq_vector,
    output logic     irq_led
);

    logic pending;

    assign pending = (irq_vector != irq_none);

    // set on a press, cleared by the cpu ack
    // presses while pending are absorbed
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= irq_none;
        end else if (pending) begin
            if (irq_ack) begin
                irq_vector <= irq_none;
            end
        end else if (key_pressed) begin
            irq_vector <= irq_keyboard;
        end
    end

    // board led shows an unserviced interrupt
    assign irq_led = pending;

endmodule

// ==== hdl/cpu_board.sv ====
`timescale 1ns/1ps
`include "cpu_board_params.svh"

// memory and peripheral fabric around the cpu core
// core sides are plain ports here
module cpu_board import board_pkg::*; (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    // instruction fetch
    input  logic                  fetch_req,
    input  logic [`CB_ADDR_W-1:0] fetch_addr,
    output logic                  fetch_valid,
    output logic [31:0]           instruction,
    // data bus
    input  logic [`CB_ADDR_W-1:0] bus_addr,
    input  logic                  bus_read,
    input  logic                  bus_write,
    input  logic [63:0]           bus_wdata,
    output logic [63:0]           bus_rdata,
    // keyboard
    input  logic                  ps2_clk,
    input  logic                  ps2_dat,
    // console
    output logic [7:0]            uart_data,
    output logic                  uart_strobe,
    // interrupt
    output irq_vec_e              irq_vector,
    input  logic                  irq_ack,
    output logic                  irq_led
);

    // decoder to arbiter
    mem_bus_if data_mem ();
    // arbiter to ram
    mem_bus_if ram_port ();

    logic [7:0] scan_code;
    logic       key_pressed;

    word_memory i_word_memory (
        .CLOCK_50 (CLOCK_50),
        .mem      (ram_port)
    );

    mem_arbiter i_mem_arbiter (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .data_side   (data_mem),
        .ram         (ram_port),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .instruction (instruction)
    );

    data_bus_decoder i_data_bus_decoder (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .bus_addr    (bus_addr),
        .bus_read    (bus_read),
        .bus_write   (bus_write),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .mem         (data_mem),
        .scan_code   (scan_code),
        .uart_data   (uart_data),
        .uart_strobe (uart_strobe)
    );

    // releases have no consumer on this board
    ps2_receiver i_ps2_receiver (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .ps2_clk      (ps2_clk),
        .ps2_dat      (ps2_dat),
        .scan_code    (scan_code),
        .key_pressed  (key_pressed),
        .key_released ()
    );

    irq_controller i_irq_controller (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_pressed (key_pressed),
        .irq_ack     (irq_ack),
        .irq_vector  (irq_vector),
        .irq_led     (irq_led)
    );

endmodule

// ==== sim/tb_cpu_board.sv ====
`timescale 1ns/1ps
`include "cpu_board_params.svh"

// directed testbench playing the cpu on both bus sides and the ps2 keyboard
module tb_cpu_board import board_pkg::*; ();

    // cycles per ps2 clock half period
    localparam int PS2_HALF_BIT     = 25;
    localparam int PS2_FRAME_CYCLES = `CB_PS2_FRAME_BITS * 2 * PS2_HALF_BIT;
    // about 8 frames plus bus traffic with a 4x margin
    localparam int TIMEOUT_CYCLES   = 4 * (8 * PS2_FRAME_CYCLES + 600);
    localparam int FETCH_WAIT       = 16;
    localparam int IRQ_MAX_DELAY    = 5;
    localparam int RAM_WORDS        = 16;

    logic                  CLOCK_50;
    logic                  KEY0;
    logic                  fetch_req;
    logic [`CB_ADDR_W-1:0] fetch_addr;
    logic                  fetch_valid;
    logic [31:0]           instruction;
    logic [`CB_ADDR_W-1:0] bus_addr;
    logic                  bus_read;
    logic                  bus_write;
    logic [63:0]           bus_wdata;
    logic [63:0]           bus_rdata;
    logic                  ps2_clk;
    logic                  ps2_dat;
    logic [7:0]            uart_data;
    logic                  uart_strobe;
    irq_vec_e              irq_vector;
    logic                  irq_ack;
    logic                  irq_led;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;
    // cycles from stop bit falling edge to interrupt or -1 for none
    int          irq_delay = -1;
    logic [31:0] rng_state = 32'hfe81_f192;
    // expected contents of the ram words under test
    logic [31:0] shadow [RAM_WORDS];

    cpu_board i_cpu_board (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .instruction (instruction),
        .bus_addr    (bus_addr),
        .bus_read    (bus_read),
        .bus_write   (bus_write),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .uart_data   (uart_data),
        .uart_strobe (uart_strobe),
        .irq_vector  (irq_vector),
        .irq_ack     (irq_ack),
        .irq_led     (irq_led)
    );

    // 50 MHz
    always #10 CLOCK_50 = ~CLOCK_50;

    // run limit
    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // fetch side sees the stored word with its bytes reversed
    function automatic logic [31:0] byte_reverse(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [`CB_ADDR_W-1:0] ram_addr(input int i);
        return `CB_RAM_BASE + `CB_ADDR_W'(i * 4);
    endfunction

    task automatic check_word(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic check_vector(input string name, input irq_vec_e expected,
                                input irq_vec_e actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED time=%0t %s expected=%s actual=%s", $time, name,
                     expected.name(), actual.name());
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %-22s ok", name);
        end else begin
            $display("test %-22s %0d errors", name, errors - errors_before);
        end
    endtask

    // one-cycle write strobe
    task automatic write_bus(input logic [`CB_ADDR_W-1:0] addr, input logic [63:0] data);
        @(posedge CLOCK_50);
        bus_addr  <= addr;
        bus_wdata <= data;
        bus_write <= 1'b1;
        @(posedge CLOCK_50);
        bus_write <= 1'b0;
    endtask

    // read data is due one cycle after the read strobe
    task automatic read_expect(input logic [`CB_ADDR_W-1:0] addr, input logic [63:0] expected);
        @(posedge CLOCK_50);
        bus_addr <= addr;
        bus_read <= 1'b1;
        @(posedge CLOCK_50);
        bus_read <= 1'b0;
        @(negedge CLOCK_50);
        check_word("bus_rdata", expected, bus_rdata);
    endtask

    // hold the request until fetch_valid and then compare
    task automatic wait_fetch(input logic [31:0] expected);
        int waited;
        waited = 0;
        @(negedge CLOCK_50);
        while (!fetch_valid && waited < FETCH_WAIT) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (!fetch_valid) begin
            report_problem("fetch request never got fetch_valid");
        end else begin
            check_word("instruction", {32'b0, expected}, {32'b0, instruction});
        end
        @(posedge CLOCK_50);
        fetch_req <= 1'b0;
    endtask

    task automatic fetch_expect(input int i);
        @(posedge CLOCK_50);
        fetch_req  <= 1'b1;
        fetch_addr <= ram_addr(i);
        wait_fetch(byte_reverse(shadow[i]));
    endtask

    // fetch i competes with n back-to-back data reads starting at word j
    task automatic fetch_with_data_traffic(input int i, input int n, input int j);
        int k;
        @(posedge CLOCK_50);
        fetch_req  <= 1'b1;
        fetch_addr <= ram_addr(i);
        bus_read   <= 1'b1;
        bus_addr   <= ram_addr(j);
        for (k = 0; k < n; k++) begin
            @(posedge CLOCK_50);
            if (k == n - 1) begin
                bus_read <= 1'b0;
            end else begin
                bus_addr <= ram_addr((j + k + 1) % RAM_WORDS);
            end
            @(negedge CLOCK_50);
            check_word("bus_rdata", {32'b0, shadow[(j + k) % RAM_WORDS]}, bus_rdata);
            if (fetch_valid) begin
                report_problem("fetch_valid came while data reads held the memory");
            end
        end
        wait_fetch(byte_reverse(shadow[i]));
    endtask

    // start bit, 8 data bits lsb first, parity, stop bit
    task automatic ps2_send_byte(input logic [7:0] code, input logic good_parity);
        logic [`CB_PS2_FRAME_BITS-1:0] frame;
        logic                          parity;
        int                            b;
        int                            k;
        parity    = (~^code) ^ !good_parity;
        frame     = {1'b1, parity, code, 1'b0};
        irq_delay = -1;
        for (b = 0; b < `CB_PS2_FRAME_BITS; b++) begin
            @(posedge CLOCK_50);
            ps2_dat <= frame[b];
            repeat (PS2_HALF_BIT - 1) @(posedge CLOCK_50);
            ps2_clk <= 1'b0;
            for (k = 0; k < PS2_HALF_BIT; k++) begin
                @(negedge CLOCK_50);
                // latency counted from the stop bit edge only
                if (b == `CB_PS2_FRAME_BITS - 1 && irq_delay < 0 &&
                    irq_vector == irq_keyboard) begin
                    irq_delay = k;
                end
                @(posedge CLOCK_50);
            end
            ps2_clk <= 1'b1;
        end
    endtask

    task automatic expect_key_irq();
        @(negedge CLOCK_50);
        if (irq_delay < 0 || irq_delay > IRQ_MAX_DELAY) begin
            report_problem("no keyboard interrupt within 5 cycles of the stop bit");
        end
        check_vector("irq_vector", irq_keyboard, irq_vector);
        check_word("irq_led", 64'd1, 64'(irq_led));
    endtask

    task automatic expect_no_irq();
        @(negedge CLOCK_50);
        if (irq_delay >= 0) begin
            report_problem("interrupt raised by a frame that should not cause one");
        end
        check_vector("irq_vector", irq_none, irq_vector);
    endtask

    task automatic acknowledge_irq();
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        @(negedge CLOCK_50);
        check_vector("irq_vector", irq_none, irq_vector);
        check_word("irq_led", 64'd0, 64'(irq_led));
    endtask

    task automatic check_reset_state();
        @(negedge CLOCK_50);
        check_word("fetch_valid", 64'd0, 64'(fetch_valid));
        check_word("uart_strobe", 64'd0, 64'(uart_strobe));
        check_byte("uart_data", 8'h00, uart_data);
        check_word("bus_rdata", 64'd0, bus_rdata);
        check_vector("irq_vector", irq_none, irq_vector);
        check_word("irq_led", 64'd0, 64'(irq_led));
    endtask

    task automatic memory_round_trip();
        logic [63:0] data;
        int          i;
        for (i = 0; i < RAM_WORDS; i++) begin
            data      = {next_random(), next_random()};
            shadow[i] = data[31:0];
            write_bus(ram_addr(i), data);
        end
        // upper half is dropped by the 32-bit memory
        for (i = 0; i < RAM_WORDS; i++) begin
            read_expect(ram_addr(i), {32'b0, shadow[i]});
        end
    endtask

    task automatic fetch_and_arbitration();
        int i;
        for (i = 0; i < RAM_WORDS; i++) begin
            fetch_expect(i);
        end
        for (i = 0; i < 8; i++) begin
            fetch_with_data_traffic(i, 1 + i % 3, (i * 5) % RAM_WORDS);
        end
    endtask

    task automatic console_strobe();
        logic [63:0] data;
        int          strobes;
        int          k;
        data    = {next_random(), next_random()};
        strobes = 0;
        @(posedge CLOCK_50);
        bus_addr  <= `CB_ART_BASE;
        bus_wdata <= data;
        bus_write <= 1'b1;
        // write held for three cycles
        for (k = 0; k < 3; k++) begin
            @(negedge CLOCK_50);
            if (uart_strobe) begin
                strobes++;
                check_byte("uart_data", data[7:0], uart_data);
            end
            @(posedge CLOCK_50);
            if (k == 2) begin
                bus_write <= 1'b0;
            end
        end
        repeat (3) begin
            @(negedge CLOCK_50);
            if (uart_strobe) begin
                strobes++;
            end
        end
        if (strobes != 1) begin
            report_problem($sformatf("console write gave %0d strobes instead of one", strobes));
        end
        check_byte("uart_data", data[7:0], uart_data);
        read_expect(`CB_ART_BASE, 64'd0);
        read_expect(ram_addr(0), {32'b0, shadow[0]});
    endtask

    task automatic key_press_interrupt();
        @(negedge CLOCK_50);
        check_vector("irq_vector", irq_none, irq_vector);
        ps2_send_byte(8'h1c, 1'b1);
        expect_key_irq();
        read_expect(`CB_KEY_BASE, 64'h1c);
        acknowledge_irq();
    endtask

    task automatic break_and_bad_frames();
        ps2_send_byte(8'hf0, 1'b1);
        expect_no_irq();
        // break prefix alone leaves the key register alone
        read_expect(`CB_KEY_BASE, 64'h1c);
        ps2_send_byte(8'h1c, 1'b1);
        expect_no_irq();
        read_expect(`CB_KEY_BASE, 64'h1c);
        // frame with wrong parity must vanish
        ps2_send_byte(8'h2d, 1'b0);
        expect_no_irq();
        read_expect(`CB_KEY_BASE, 64'h1c);
        ps2_send_byte(8'h2d, 1'b1);
        expect_key_irq();
        read_expect(`CB_KEY_BASE, 64'h2d);
        acknowledge_irq();
    endtask

    task automatic unmapped_access();
        logic [7:0]  uart_before;
        logic [31:0] rom_word;
        int          i;
        // 0x2010 would alias rom word 4 if decoded as memory
        rom_word = next_random();
        write_bus(16'h0010, {32'b0, rom_word});
        read_expect(16'h2010, 64'd0);
        uart_before = uart_data;
        @(posedge CLOCK_50);
        bus_addr  <= 16'h2010;
        bus_wdata <= {next_random(), next_random()};
        bus_write <= 1'b1;
        @(negedge CLOCK_50);
        if (uart_strobe) begin
            report_problem("console strobe fired for a write to an unmapped address");
        end
        @(posedge CLOCK_50);
        bus_write <= 1'b0;
        @(negedge CLOCK_50);
        check_byte("uart_data", uart_before, uart_data);
        read_expect(16'h0010, {32'b0, rom_word});
        for (i = 0; i < RAM_WORDS; i++) begin
            read_expect(ram_addr(i), {32'b0, shadow[i]});
        end
    endtask

    initial begin
        int start;
        CLOCK_50   = 1'b0;
        KEY0       = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        bus_addr   = '0;
        bus_read   = 1'b0;
        bus_write  = 1'b0;
        bus_wdata  = '0;
        // ps2 lines idle high
        ps2_clk    = 1'b1;
        ps2_dat    = 1'b1;
        irq_ack    = 1'b0;
        repeat (8) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        start = errors;
        check_reset_state();
        report_test("reset state", start);
        start = errors;
        memory_round_trip();
        report_test("memory round trip", start);
        start = errors;
        fetch_and_arbitration();
        report_test("fetch and arbitration", start);
        start = errors;
        console_strobe();
        report_test("console strobe", start);
        start = errors;
        key_press_interrupt();
        report_test("key press interrupt", start);
        start = errors;
        break_and_bad_frames();
        report_test("break and bad frames", start);
        start = errors;
        unmapped_access();
        report_test("unmapped address", start);

        $display("tests %0d, checks %0d, errors %0d, cycles %0d", tests, checks, errors, cycles);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== cpu_board.f ====
+incdir+hdl
hdl/board_pkg.sv
hdl/mem_bus_if.sv
hdl/word_memory.sv
hdl/mem_arbiter.sv
hdl/data_bus_decoder.sv
hdl/ps2_receiver.sv
hdl/irq_controller.sv
hdl/cpu_board.sv
sim/tb_cpu_board.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the cpu_board testbench with verilator and runs it
# exit status is nonzero when the build fails or the run reports failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cpu_board -f cpu_board.f -o tb_cpu_board \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_cpu_board > sim.log 2>&1
cat sim.log

# a run that never printed its pass line counts as failed too
! grep -q "Simulation failed" sim.log && grep -q "Simulation passed" sim.log \
    && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }
